// File: design/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int DEFAULT_WIDTH = 16;  // Operand and result width
    localparam int KEY_MAX       = 9;   // Highest decimal key accepted

    // Operator codes as the keypad delivers them, one-hot
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } calc_op_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        ENTER_FIRST  = 3'd0,  // Building first operand
        ENTER_SECOND = 3'd1,  // Building second operand
        ISSUE        = 3'd2,  // Start pulse to selected unit
        WAIT_RESULT  = 3'd3,  // Waiting for finish
        SHOW_RESULT  = 3'd4   // Result to display, complete pulse
    } calc_state_t;

endpackage

`default_nettype wire

// File: design/arith_if.sv
`default_nettype none

// One request/response channel between the controller and one arithmetic unit
interface arith_if #(
    parameter int DATA_WIDTH = calc_pkg::DEFAULT_WIDTH
);

    logic [DATA_WIDTH-1:0] in1;     // First operand, stable start to finish
    logic [DATA_WIDTH-1:0] in2;     // Second operand
    logic                  start;   // One-cycle request strobe
    logic [DATA_WIDTH-1:0] result;  // Valid with finish, held after
    logic                  finish;  // One-cycle done strobe

    modport requester (
        output in1,
        output in2,
        output start,
        input  result,
        input  finish
    );

    modport unit (
        input  in1,
        input  in2,
        input  start,
        output result,
        output finish
    );

endinterface

`default_nettype wire

// File: design/calc_control.sv
`default_nettype none

module calc_control #(
    parameter int DATA_WIDTH = calc_pkg::DEFAULT_WIDTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            keypad_input,    // Single digit from keypad
    input  logic                  read_input,      // Digit strobe
    input  logic [2:0]            operator_input,  // One-hot operator code
    input  logic                  equal_input,     // Equal key
    arith_if.requester            add_bus,         // Adder/subtractor channel
    output logic                  sub_select,      // High selects subtraction
    arith_if.requester            mul_bus,         // Multiplier channel
    output logic                  complete,        // One-cycle result pulse
    output logic [DATA_WIDTH-1:0] display_output   // Last result, held
);
    import calc_pkg::*;

    calc_state_t           state;
    calc_state_t           state_next;
    calc_op_t              op_q;         // Operator latched at key press
    logic [DATA_WIDTH-1:0] operand1;
    logic [DATA_WIDTH-1:0] operand2;
    logic [DATA_WIDTH-1:0] entry_src;    // Operand being keyed in
    logic [DATA_WIDTH-1:0] entry_next;   // Ten times old value plus digit
    logic                  digit_valid;
    logic                  op_valid;
    logic                  is_mul;
    logic                  unit_finish;

    assign digit_valid = read_input && (keypad_input <= KEY_MAX);  // Keys 10..15 dropped
    assign is_mul      = (op_q == OP_MUL);
    assign unit_finish = is_mul ? mul_bus.finish : add_bus.finish;

    // Only the three one-hot codes count as an operator
    always_comb begin
        case (operator_input)
            OP_ADD, OP_SUB, OP_MUL: op_valid = 1'b1;
            default:                op_valid = 1'b0;
        endcase
    end

    // x*10 as x*8 + x*2, wraps at DATA_WIDTH
    assign entry_src  = (state == ENTER_SECOND) ? operand2 : operand1;
    assign entry_next = (entry_src << 3) + (entry_src << 1) + DATA_WIDTH'(keypad_input);

    // Both channels see the same operands; start picks the unit
    assign add_bus.in1 = operand1;
    assign add_bus.in2 = operand2;
    assign mul_bus.in1 = operand1;
    assign mul_bus.in2 = operand2;

    always_comb begin
        state_next = state;
        case (state)
            ENTER_FIRST: begin
                if (op_valid) begin
                    state_next = ENTER_SECOND;
                end
            end
            ENTER_SECOND: begin
                if (equal_input) begin
                    state_next = ISSUE;
                end
            end
            ISSUE: begin
                state_next = WAIT_RESULT;
            end
            WAIT_RESULT: begin
                if (unit_finish) begin
                    state_next = SHOW_RESULT;
                end
            end
            SHOW_RESULT: begin
                state_next = ENTER_FIRST;  // Next calculation starts fresh
            end
            default: begin
                state_next = ENTER_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_FIRST;
        end else begin
            state <= state_next;
        end
    end

    // Operand entry; operator beats digit, equal beats digit
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand1 <= '0;
            operand2 <= '0;
        end else begin
            case (state)
                ENTER_FIRST: begin
                    if (!op_valid && digit_valid) begin
                        operand1 <= entry_next;
                    end
                end
                ENTER_SECOND: begin
                    if (!equal_input && digit_valid) begin
                        operand2 <= entry_next;
                    end
                end
                SHOW_RESULT: begin
                    operand1 <= '0;  // Clear for next entry
                    operand2 <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_q <= OP_ADD;
        end else if (state == ENTER_FIRST && op_valid) begin
            op_q <= calc_op_t'(operator_input);  // Held through the calculation
        end
    end

    // Dispatch and result capture
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            add_bus.start  <= 1'b0;
            mul_bus.start  <= 1'b0;
            sub_select     <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            add_bus.start <= (state == ISSUE) && !is_mul;  // Single pulse, ISSUE lasts one cycle
            mul_bus.start <= (state == ISSUE) && is_mul;
            complete      <= (state == SHOW_RESULT);
            if (state == ISSUE) begin
                sub_select <= (op_q == OP_SUB);  // Level, stays until next issue
            end
            if (state == SHOW_RESULT) begin
                display_output <= is_mul ? mul_bus.result : add_bus.result;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/add_sub_unit.sv
`default_nettype none

module add_sub_unit #(
    parameter int DATA_WIDTH = calc_pkg::DEFAULT_WIDTH
) (
    input  logic   clk,
    input  logic   nRST,
    arith_if.unit  bus,         // Request from controller
    input  logic   sub_select   // High for in1 - in2
);

    logic [DATA_WIDTH-1:0] operand_b;  // in2 or its ones' complement
    logic [DATA_WIDTH-1:0] sum;

    // Subtract as in1 + ~in2 + 1, carry out dropped so it wraps
    assign operand_b = sub_select ? ~bus.in2 : bus.in2;
    assign sum       = bus.in1 + operand_b + DATA_WIDTH'(sub_select);

    // Finish one cycle after start
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= bus.start;
        end
    end

    // Result held until the next start
    always_ff @(posedge clk) begin
        if (bus.start) begin
            bus.result <= sum;
        end
    end

endmodule

`default_nettype wire

// File: design/shift_add_multiplier.sv
`default_nettype none

module shift_add_multiplier #(
    parameter int DATA_WIDTH = calc_pkg::DEFAULT_WIDTH
) (
    input  logic  clk,
    input  logic  nRST,
    arith_if.unit bus          // Request from controller
);

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);  // Holds DATA_WIDTH

    logic [DATA_WIDTH-1:0] mcand;     // Multiplicand, shifted left each step
    logic [DATA_WIDTH-1:0] mplier;    // Multiplier, shifted right each step
    logic [DATA_WIDTH-1:0] acc;       // Partial product, low half only
    logic [DATA_WIDTH-1:0] acc_next;
    logic [CNT_W-1:0]      bit_cnt;   // Multiplier bits left
    logic                  busy;

    assign acc_next = mplier[0] ? acc + mcand : acc;

    // Last step shows through combinationally so finish lands DATA_WIDTH
    // cycles after start; once idle mplier is zero and this is just acc
    assign bus.result = acc_next;
    assign bus.finish = busy && (bit_cnt == CNT_W'(1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (bus.start) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(DATA_WIDTH);  // One step per multiplier bit
            end
        end else begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == CNT_W'(1)) begin
                busy <= 1'b0;  // Done after the final step
            end
        end
    end

    // Datapath; start while busy is ignored
    always_ff @(posedge clk) begin
        if (!busy) begin
            if (bus.start) begin
                mcand  <= bus.in1;
                mplier <= bus.in2;
                acc    <= '0;
            end
        end else begin
            acc    <= acc_next;
            mcand  <= mcand << 1;   // Bits past DATA_WIDTH fall off
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// File: design/calculator_top.sv
`default_nettype none

module calculator_top #(
    parameter int DATA_WIDTH = calc_pkg::DEFAULT_WIDTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            keypad_input,    // Digit 0..9
    input  logic                  read_input,      // Digit strobe
    input  logic [2:0]            operator_input,  // 001 add, 010 sub, 100 mul
    input  logic                  equal_input,
    output logic                  complete,        // One-cycle done pulse
    output logic [DATA_WIDTH-1:0] display_output
);

    arith_if #(.DATA_WIDTH(DATA_WIDTH)) add_bus ();  // Controller to add/sub
    arith_if #(.DATA_WIDTH(DATA_WIDTH)) mul_bus ();  // Controller to multiplier

    logic sub_select;  // Only the add/sub unit needs it

    calc_control #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_calc_control (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_bus        (add_bus),
        .sub_select     (sub_select),
        .mul_bus        (mul_bus),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_add_sub_unit (
        .clk        (clk),
        .nRST       (nRST),
        .bus        (add_bus),
        .sub_select (sub_select)
    );

    shift_add_multiplier #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_shift_add_multiplier (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus)
    );

endmodule

`default_nettype wire

// File: verif/calculator_tb.sv
`default_nettype none

module calculator_tb;
    import calc_pkg::*;

    localparam int W              = 16;
    localparam int NUM_CALCS      = 40;
    localparam int TIMEOUT_CYCLES = 3000;  // ~40 calcs, strobes plus gaps plus compute

    logic         clk            = 1'b0;
    logic         nRST           = 1'b0;
    logic [3:0]   keypad_input   = 4'd0;
    logic         read_input     = 1'b0;
    logic [2:0]   operator_input = 3'b000;
    logic         equal_input    = 1'b0;
    logic         complete;
    logic [W-1:0] display_output;

    logic [31:0]  lfsr_state  = 32'h98ae;
    logic [W-1:0] exp_result  = '0;    // Model answer for the pending calculation
    logic         pending     = 1'b0;  // Equal pressed, result not yet seen
    int           cycle_count = 0;

    calculator_top #(
        .DATA_WIDTH (W)
    ) i_calculator_top (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #50 clk = ~clk;  // 100 unit period

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("FAIL t=%0t %s expected %0h actual %0h",
                                    $time, name, expected, actual));
    endtask

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = next_lfsr(lfsr_state);  // One step per bit
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Decimal entry rule, keys above KEY_MAX leave the operand alone
    function automatic logic [W-1:0] append_digit(input logic [W-1:0] acc, input int key);
        logic [W-1:0] next;
        next = acc;
        if (key <= KEY_MAX) begin
            next = acc * 10 + key;  // Truncates to W bits
        end
        return next;
    endfunction

    function automatic logic [W-1:0] model_result(input calc_op_t op, input logic [W-1:0] a,
                                                  input logic [W-1:0] b);
        logic [2*W-1:0] product;
        logic [W-1:0]   r;
        product = a * b;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;            // Two's complement wrap
            default: r = product[W-1:0];   // Low half of product
        endcase
        return r;
    endfunction

    function automatic logic [2:0] bad_operator(input int sel);
        case (sel)
            0:       return 3'b011;
            1:       return 3'b101;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    task automatic press_key(input int key);
        int gap;
        gap = take_bits(2);
        @(posedge clk);
        keypad_input <= 4'(key);
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic press_operator(input logic [2:0] code);
        int gap;
        gap = take_bits(2);
        @(posedge clk);
        operator_input <= code;
        @(posedge clk);
        operator_input <= 3'b000;
        repeat (gap) @(posedge clk);
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;  // No gap, caller may flood right after
    endtask

    task automatic enter_number(input bit bad_keys, inout logic [W-1:0] acc);
        int count;
        int key;
        count = take_bits(3) % 5 + 1;  // One to five digits
        for (int d = 0; d < count; d++) begin
            if (bad_keys && (d == 0 || take_bits(1) == 1)) begin
                key = 10 + take_bits(3) % 6;  // Keys 10..15
                press_key(key);
                acc = append_digit(acc, key);
            end
            key = take_bits(4) % 10;
            press_key(key);
            acc = append_digit(acc, key);
        end
    endtask

    // Inputs sampled in ISSUE and WAIT_RESULT, all must be dropped
    task automatic flood_during_compute();
        keypad_input   <= 4'd7;
        read_input     <= 1'b1;
        operator_input <= OP_MUL;
        equal_input    <= 1'b1;
        repeat (3) @(posedge clk);  // Stays inside the 4 cycle minimum latency
        read_input     <= 1'b0;
        operator_input <= 3'b000;
        equal_input    <= 1'b0;
    endtask

    // Mode 1 bad keys, 2 bad operator, 3 early equal, 4 flood while busy
    task automatic run_calc(input int op_sel, input int mode);
        logic [W-1:0] a;
        logic [W-1:0] b;
        calc_op_t     op;
        a  = '0;  // Both operands start fresh
        b  = '0;
        op = (op_sel == 0) ? OP_ADD : (op_sel == 1) ? OP_SUB : OP_MUL;
        enter_number(mode == 1, a);
        if (mode == 2) begin
            press_operator(bad_operator(take_bits(2)));
        end
        if (mode == 3) begin
            press_equal();  // Ignored in ENTER_FIRST
        end
        press_operator(op);
        enter_number(mode == 1, b);
        exp_result <= model_result(op, a, b);
        pending    <= 1'b1;
        press_equal();
        if (mode == 4) begin
            flood_during_compute();
        end
        do @(posedge clk); while (complete !== 1'b1);
        pending <= 1'b0;
    endtask

    initial begin
        repeat (8) @(posedge clk);
        nRST <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_CALCS; i++) begin
            run_calc(i % 3, (i / 3) % 5);  // Every op and mode pair in 15 calcs
            repeat (take_bits(2)) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("test passed");
        $finish;
    end

    always @(posedge clk) begin
        calc_state_t ctrl_state;
        ctrl_state  = i_calculator_top.i_calc_control.state;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles, controller in %s",
                                        cycle_count, ctrl_state.name()));
        end
    end

    reset_clears_complete: assert property (@(posedge clk) !nRST |=> !complete)
        else report_mismatch("complete", 32'd0, 32'($sampled(complete)));

    reset_clears_display: assert property (@(posedge clk) !nRST |=> display_output == '0)
        else report_mismatch("display_output", 32'd0, 32'($sampled(display_output)));

    display_matches_model: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> display_output == exp_result)
        else report_mismatch("display_output", 32'($sampled(exp_result)),
                             32'($sampled(display_output)));

    complete_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else report_mismatch("complete", 32'd0, 32'($sampled(complete)));

    complete_only_when_pending: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> pending)
        else stop_with_failure($sformatf("t=%0t complete pulsed with no calculation pending",
                                         $time));

    display_holds: assert property (@(posedge clk) disable iff (!nRST)
        $changed(display_output) |-> complete)
        else stop_with_failure($sformatf("t=%0t display_output changed without complete",
                                         $time));

endmodule

`default_nettype wire

// File: vlog.f
design/calc_pkg.sv
design/arith_if.sv
design/calc_control.sv
design/add_sub_unit.sv
design/shift_add_multiplier.sv
design/calculator_top.sv
verif/calculator_tb.sv
